/* design/backoffTrigPkg.sv */
/* shared sizes, DMA queue codes and grouped signal types of the backoff
   protocol trigger; referenced by scoped names, never imported */
`default_nettype none

package backoffTrigPkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int NUM_AC = 4;                // AC0 (lowest) .. AC3 (highest)

  typedef logic [NUM_AC-1:0] acVec_t;       // one bit per AC
  typedef logic [1:0]        acIdx_t;       // AC number
  typedef logic [15:0]       backoffCnt_t;  // backoff counter value
  typedef logic [11:0]       aifsCnt_t;     // AIFS counter value
  typedef logic [7:0]        slotCnt_t;     // slot count, slot time, trigger time

  //////////////////////////////
  // DMA queue state
  //////////////////////////////
  // any code not listed here reads as idle
  typedef enum logic [3:0] {
    PASSIVE = 4'd2,                         // waiting for the MAC controller
    ACTIVE  = 4'd4                          // dma transfer running
  } dmaState_t;

  typedef dmaState_t [NUM_AC-1:0] txStateVec_t;   // queue state per AC

  //////////////////////////////
  // grouped signals
  //////////////////////////////
  typedef struct packed {
    backoffCnt_t [NUM_AC-1:0] backoffCnt;   // backoff count per AC
    aifsCnt_t    [NUM_AC-1:0] aifsCnt;      // remaining AIFS per AC
  } acTimers_t;

  typedef struct packed {
    logic [15:0] slotValue;                 // trigger time / slot time
    logic [15:0] remValue;                  // what is left in us
  } trigThreshold_t;

  typedef struct packed {
    acVec_t setHasData;                     // set strobes, win over clear
    acVec_t clearHasData;                   // clear strobes
  } hasDataCtrl_t;

endpackage

`default_nettype wire

/* design/trigThresholdCalc.sv */
/* converts the EDCA trigger time into a slot threshold and a remainder by
   restoring division by the slot time, one quotient bit per cycle */
`timescale 1ns/10ps
`default_nettype none

module trigThresholdCalc
(
  input  wire                            macCoreClk,          // mac core clock
  input  wire                            macCoreClkHardRst_n, // async reset, active low
  input  wire                            currentStateEvent,   // restarts the division
  input  wire backoffTrigPkg::slotCnt_t  edcaTriggerTimer,    // dividend in us
  input  wire backoffTrigPkg::slotCnt_t  slotTime,            // divisor in us
  output backoffTrigPkg::trigThreshold_t threshold            // quotient and remainder
);

  //////////////////////////////
  // division state
  //////////////////////////////
  logic [2:0]  shiftIdx;     // quotient bit decided this cycle
  logic        calcBusy;     // steps still to run
  logic [15:0] slotShifted;  // slot time aligned on shiftIdx

  // 255 << 7 still fits in 16 bits
  assign slotShifted = {8'h00, slotTime} << shiftIdx;

  // quotient and remainder are visible downstream while the steps run
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      threshold <= '0;
      shiftIdx  <= 3'd7;
      calcBusy  <= 1'b0;
    end
    else if (currentStateEvent)
    begin
      // restart from msb with the full trigger time
      threshold.slotValue <= 16'h0000;
      threshold.remValue  <= {8'h00, edcaTriggerTimer};
      shiftIdx            <= 3'd7;
      calcBusy            <= 1'b1;
    end
    else if (calcBusy)
    begin
      if (threshold.remValue >= slotShifted)      // divisor fits at this weight
      begin
        threshold.remValue            <= threshold.remValue - slotShifted;
        threshold.slotValue[shiftIdx] <= 1'b1;
      end
      shiftIdx <= shiftIdx - 3'd1;
      if (shiftIdx == 3'd0)                       // lsb done, 8th step
        calcBusy <= 1'b0;
    end
  end

  // between events the last result simply stays in place

endmodule

`default_nettype wire

/* design/acTrigDetect.sv */
/* marks each AC close to the end of its backoff on the slot tick, from the
   backoff, AIFS and slot counters against the threshold; delays the tick */
`timescale 1ns/10ps
`default_nettype none

module acTrigDetect
(
  input  wire                                macCoreClk,          // mac core clock
  input  wire                                macCoreClkHardRst_n, // async reset, active low
  input  wire                                backoffEnable,       // core in backoff
  input  wire                                tickSlot1us_p,       // us tick aligned on slotCnt
  input  wire backoffTrigPkg::acTimers_t     timers,              // backoff and AIFS counts
  input  wire backoffTrigPkg::slotCnt_t      slotCnt,             // slot counter
  input  wire backoffTrigPkg::trigThreshold_t threshold,          // slot threshold, remainder
  output backoffTrigPkg::acVec_t             acTrig,              // near end marks
  output logic                               checkStrobe          // marks fresh and not empty
);

  backoffTrigPkg::acVec_t nearEnd;    // mark value for the next tick
  logic                   tickDly_p;  // tick one cycle late

  //////////////////////////////
  // near end of backoff
  //////////////////////////////
  always_comb
  begin
    for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
    begin
      if (timers.backoffCnt[i] < threshold.slotValue)
        nearEnd[i] = 1'b1;                           // fewer slots left than threshold
      else if (timers.backoffCnt[i] == threshold.slotValue)
      begin
        // last slot, look inside it
        if (timers.aifsCnt[i] == '0)
          nearEnd[i] = (slotCnt <= threshold.remValue[7:0]);     // AIFS over, slot count
        else
          nearEnd[i] = (timers.aifsCnt[i] <= threshold.remValue[11:0]); // still in AIFS
      end
      else
        nearEnd[i] = 1'b0;
    end
  end

  // marks sampled on tick only, held in between
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      acTrig <= '0;
    else if (!backoffEnable)
      acTrig <= '0;                  // no backoff, nothing near its end
    else if (tickSlot1us_p)
      acTrig <= nearEnd;
  end

  //////////////////////////////
  // delayed tick
  //////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      tickDly_p <= 1'b0;
    else
      tickDly_p <= tickSlot1us_p;
  end

  // selection only worth running when some AC is marked
  assign checkStrobe = tickDly_p & (|acTrig);

endmodule

`default_nettype wire

/* design/acPrioritySelect.sv */
/* keeps the per-AC has-data status and registers the highest eligible AC
   among the marked ones once per check strobe */
`timescale 1ns/10ps
`default_nettype none

module acPrioritySelect
(
  input  wire                                macCoreClk,          // mac core clock
  input  wire                                macCoreClkHardRst_n, // async reset, active low
  input  wire backoffTrigPkg::acVec_t        acTrig,              // near end marks
  input  wire                                checkStrobe,         // marks fresh this cycle
  input  wire backoffTrigPkg::hasDataCtrl_t  hasDataCtrl,         // set and clear strobes
  input  wire backoffTrigPkg::txStateVec_t   txState,             // DMA queue states
  output backoffTrigPkg::acIdx_t             trigIdx,             // selected AC
  output logic                               trigIdxValid,        // trigIdx usable
  output backoffTrigPkg::acVec_t             hasData              // has-data status
);

  backoffTrigPkg::acVec_t queueBusy;  // queue PASSIVE or ACTIVE
  backoffTrigPkg::acVec_t eligible;   // marked and worth a trigger
  backoffTrigPkg::acIdx_t topIdx;     // highest eligible AC

  //////////////////////////////
  // has-data status
  //////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      hasData <= '0;
    else
      hasData <= hasDataCtrl.setHasData | (hasData & ~hasDataCtrl.clearHasData); // set wins
  end

  //////////////////////////////
  // eligibility and priority
  //////////////////////////////
  always_comb
  begin
    for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
    begin
      queueBusy[i] = (txState[i] == backoffTrigPkg::PASSIVE) ||
                     (txState[i] == backoffTrigPkg::ACTIVE);
    end
  end

  assign eligible = acTrig & (hasData | queueBusy);

  // ascending scan, last hit is the highest AC
  always_comb
  begin
    topIdx = '0;
    for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
    begin
      if (eligible[i])
        topIdx = backoffTrigPkg::acIdx_t'(i);
    end
  end

  // one cycle valid per check, no fallback kept
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      trigIdx      <= '0;
      trigIdxValid <= 1'b0;
    end
    else if (checkStrobe && (|eligible))
    begin
      trigIdx      <= topIdx;
      trigIdxValid <= 1'b1;
    end
    else
    begin
      trigIdx      <= '0;
      trigIdxValid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/protTrigPulseGen.sv */
/* turns the selected AC index into a one-cycle protocol trigger pulse and
   keeps the per-AC flags that allow only one pulse per backoff */
`timescale 1ns/10ps
`default_nettype none

module protTrigPulseGen
(
  input  wire                          macCoreClk,          // mac core clock
  input  wire                          macCoreClkHardRst_n, // async reset, active low
  input  wire backoffTrigPkg::acIdx_t  trigIdx,             // selected AC
  input  wire                          trigIdxValid,        // selection this cycle
  input  wire                          txInProgress,        // tx ongoing, no trigger
  input  wire backoffTrigPkg::acVec_t  hasData,             // has-data status
  input  wire backoffTrigPkg::acVec_t  flagReset,           // flag reset from interrupt ctrl
  input  wire backoffTrigPkg::acVec_t  clearHasData,        // has-data clear strobes
  output backoffTrigPkg::acVec_t       protTrigger          // trigger pulses
);

  backoffTrigPkg::acVec_t selOneHot;  // decoded index
  backoffTrigPkg::acVec_t trigFlag;   // AC already triggered

  always_comb
  begin
    selOneHot          = '0;
    selOneHot[trigIdx] = 1'b1;
  end

  //////////////////////////////
  // trigger pulse
  //////////////////////////////
  // selected AC only; if it is blocked nobody pulses
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      protTrigger <= '0;
    else if (trigIdxValid && !txInProgress)
      protTrigger <= selOneHot & ~trigFlag & hasData;
    else
      protTrigger <= '0;                 // dropped, not queued
  end

  //////////////////////////////
  // one-shot flags
  //////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      trigFlag <= '0;
    else
    begin
      for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
      begin
        if (protTrigger[i])
          trigFlag[i] <= 1'b1;           // remember the pulse
        else if (flagReset[i] || clearHasData[i])
          trigFlag[i] <= 1'b0;           // queue served or emptied
      end
    end
  end

endmodule

`default_nettype wire

/* design/backoffProtTrig.sv */
/* backoff protocol trigger top level; threshold calc, detection, priority
   selection and pulse generation chained with a fixed 3 cycle tick latency */
`timescale 1ns/10ps
`default_nettype none

module backoffProtTrig
(
  input  wire                               macCoreClk,          // mac core clock
  input  wire                               macCoreClkHardRst_n, // async reset, active low
  input  wire                               currentStateEvent,   // core state event
  input  wire                               backoffEnable,       // core in backoff
  input  wire                               tickSlot1us_p,       // us tick aligned on slotCnt
  input  wire                               txInProgress,        // tx ongoing
  input  wire backoffTrigPkg::slotCnt_t     edcaTriggerTimer,    // trigger time in us
  input  wire backoffTrigPkg::slotCnt_t     slotTime,            // slot time in us
  input  wire backoffTrigPkg::slotCnt_t     slotCnt,             // slot counter
  input  wire backoffTrigPkg::acTimers_t    timers,              // backoff and AIFS counts
  input  wire backoffTrigPkg::txStateVec_t  txState,             // DMA queue states
  input  wire backoffTrigPkg::hasDataCtrl_t hasDataCtrl,         // has-data strobes
  input  wire backoffTrigPkg::acVec_t       flagReset,           // trigger flag resets
  output backoffTrigPkg::acVec_t            protTrigger,         // trigger pulses
  output backoffTrigPkg::acVec_t            hasDataStatus        // has-data status
);

  //////////////////////////////
  // internal links
  //////////////////////////////
  backoffTrigPkg::trigThreshold_t threshold;     // calc to detect
  backoffTrigPkg::acVec_t         acTrig;        // marks
  logic                           checkStrobe;   // tick + 1, marks present
  backoffTrigPkg::acIdx_t         trigIdx;       // selected AC
  logic                           trigIdxValid;

  trigThresholdCalc uThresholdCalc (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .currentStateEvent   (currentStateEvent),
    .edcaTriggerTimer    (edcaTriggerTimer),
    .slotTime            (slotTime),
    .threshold           (threshold)
  );

  // tick n -> marks n+1
  acTrigDetect uTrigDetect (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .backoffEnable       (backoffEnable),
    .tickSlot1us_p       (tickSlot1us_p),
    .timers              (timers),
    .slotCnt             (slotCnt),
    .threshold           (threshold),
    .acTrig              (acTrig),
    .checkStrobe         (checkStrobe)
  );

  // index valid n+2
  acPrioritySelect uPrioritySelect (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .acTrig              (acTrig),
    .checkStrobe         (checkStrobe),
    .hasDataCtrl         (hasDataCtrl),
    .txState             (txState),
    .trigIdx             (trigIdx),
    .trigIdxValid        (trigIdxValid),
    .hasData             (hasDataStatus)
  );

  // pulse n+3
  protTrigPulseGen uPulseGen (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .trigIdx             (trigIdx),
    .trigIdxValid        (trigIdxValid),
    .txInProgress        (txInProgress),
    .hasData             (hasDataStatus),
    .flagReset           (flagReset),
    .clearHasData        (hasDataCtrl.clearHasData),
    .protTrigger         (protTrigger)
  );

endmodule

`default_nettype wire

/* verification/trigRefModel.svh */
/* reference rules of the backoff protocol trigger, included inside the
   testbench module; the testbench keeps the state between cycles */
`ifndef TRIG_REF_MODEL_SVH
`define TRIG_REF_MODEL_SVH

//////////////////////////////
// threshold
//////////////////////////////
// plain integer quotient and rest
function automatic backoffTrigPkg::trigThreshold_t expectedThreshold(
  input backoffTrigPkg::slotCnt_t trigTime,
  input backoffTrigPkg::slotCnt_t slot
);
  backoffTrigPkg::trigThreshold_t th;
  th.slotValue = {8'h00, trigTime / slot};
  th.remValue  = {8'h00, trigTime % slot};
  return th;
endfunction

//////////////////////////////
// detect and select
//////////////////////////////
function automatic backoffTrigPkg::acVec_t expectedMarks(
  input backoffTrigPkg::acTimers_t      t,
  input backoffTrigPkg::slotCnt_t       sc,
  input backoffTrigPkg::trigThreshold_t th
);
  backoffTrigPkg::acVec_t m;
  m = '0;
  for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
  begin
    if (t.backoffCnt[i] < th.slotValue)
      m[i] = 1'b1;                                   // below threshold
    else if (t.backoffCnt[i] == th.slotValue && t.aifsCnt[i] == 12'd0)
      m[i] = (sc <= th.remValue[7:0]);               // aifs done, slot count
    else if (t.backoffCnt[i] == th.slotValue)
      m[i] = (t.aifsCnt[i] <= th.remValue[11:0]);    // still in aifs
  end
  return m;
endfunction

// top-down search, -1 when nothing eligible
function automatic int selectedAc(
  input backoffTrigPkg::acVec_t      marks,
  input backoffTrigPkg::acVec_t      hasData,
  input backoffTrigPkg::txStateVec_t queues
);
  for (int i = backoffTrigPkg::NUM_AC - 1; i >= 0; i--)
  begin
    if (marks[i] && (hasData[i] || queues[i] == backoffTrigPkg::PASSIVE ||
        queues[i] == backoffTrigPkg::ACTIVE))
      return i;
  end
  return -1;
endfunction

//////////////////////////////
// pulse, flags, has-data
//////////////////////////////
// no fallback to a lower AC
function automatic backoffTrigPkg::acVec_t expectedPulse(
  input int                     sel,
  input logic                   txBusy,
  input backoffTrigPkg::acVec_t flags,
  input backoffTrigPkg::acVec_t hasData
);
  backoffTrigPkg::acVec_t hit;
  hit = '0;
  if (sel >= 0 && !txBusy && !flags[sel] && hasData[sel])
    hit[sel] = 1'b1;
  return hit;
endfunction

function automatic backoffTrigPkg::acVec_t nextFlags(
  input backoffTrigPkg::acVec_t flags,
  input backoffTrigPkg::acVec_t pulse,
  input backoffTrigPkg::acVec_t flagRst,
  input backoffTrigPkg::acVec_t clrHd
);
  return pulse | (flags & ~(flagRst | clrHd));     // pulse beats reset
endfunction

function automatic backoffTrigPkg::acVec_t nextHasData(
  input backoffTrigPkg::acVec_t hasData,
  input backoffTrigPkg::acVec_t setHd,
  input backoffTrigPkg::acVec_t clrHd
);
  backoffTrigPkg::acVec_t hd;
  hd = hasData;
  for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
  begin
    if (setHd[i])
      hd[i] = 1'b1;                                  // set wins
    else if (clrHd[i])
      hd[i] = 1'b0;
  end
  return hd;
endfunction

`endif

/* verification/backoffProtTrigTb.sv */
/* self-checking testbench of the backoff protocol trigger; directed and LFSR
   ticks against the reference rules, built and run through the Makefile */
`timescale 1ns/10ps
`default_nettype none

module backoffProtTrigTb;

  logic                         macCoreClk;
  logic                         macCoreClkHardRst_n;
  logic                         currentStateEvent;
  logic                         backoffEnable;
  logic                         tickSlot1us_p;
  logic                         txInProgress;
  backoffTrigPkg::slotCnt_t     edcaTriggerTimer;
  backoffTrigPkg::slotCnt_t     slotTime;
  backoffTrigPkg::slotCnt_t     slotCnt;
  backoffTrigPkg::acTimers_t    timers;
  backoffTrigPkg::txStateVec_t  txState;
  backoffTrigPkg::hasDataCtrl_t hasDataCtrl;
  backoffTrigPkg::acVec_t       flagReset;
  backoffTrigPkg::acVec_t       protTrigger;
  backoffTrigPkg::acVec_t       hasDataStatus;

  // reference state, updated on the same edges as the DUT
  backoffTrigPkg::trigThreshold_t refThreshold;
  backoffTrigPkg::acVec_t         refMarks;
  logic                           refTickDly;
  int                             refSel;       // -1 no selection
  backoffTrigPkg::acVec_t         refPulse;
  backoffTrigPkg::acVec_t         refFlags;
  backoffTrigPkg::acVec_t         refHasData;
  logic [31:0]                    lfsrState;

  `include "trigRefModel.svh"

  backoffProtTrig UUT (.*);

  initial
  begin
    macCoreClk = 1'b0;
    forever #10 macCoreClk = ~macCoreClk;     // 20 ns
  end

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  //////////////////////////////
  // random source
  //////////////////////////////
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  //////////////////////////////
  // reference and compare
  //////////////////////////////
  always @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    backoffTrigPkg::acVec_t pulseNow;
    if (!macCoreClkHardRst_n)
    begin
      refThreshold = '0;
      refMarks     = '0;
      refTickDly   = 1'b0;
      refSel       = -1;
      refPulse     = '0;
      refFlags     = '0;
      refHasData   = '0;
    end
    else
    begin
      // everything from the values before this edge
      pulseNow   = expectedPulse(refSel, txInProgress, refFlags, refHasData);
      refFlags   = nextFlags(refFlags, refPulse, flagReset, hasDataCtrl.clearHasData);
      refPulse   = pulseNow;
      refSel     = refTickDly ? selectedAc(refMarks, refHasData, txState) : -1;
      refHasData = nextHasData(refHasData, hasDataCtrl.setHasData, hasDataCtrl.clearHasData);
      if (!backoffEnable)
        refMarks = '0;
      else if (tickSlot1us_p)
        refMarks = expectedMarks(timers, slotCnt, refThreshold);
      refTickDly = tickSlot1us_p;
      if (currentStateEvent)
        refThreshold = expectedThreshold(edcaTriggerTimer, slotTime);
    end
  end

  always @(negedge macCoreClk)
  begin
    assert (protTrigger === refPulse)
    else stopRun($sformatf("Mismatch at %0t: protTrigger is %b, expected %b",
                           $time, protTrigger, refPulse));
    assert (hasDataStatus === refHasData)
    else stopRun($sformatf("Mismatch at %0t: hasDataStatus is %b, expected %b",
                           $time, hasDataStatus, refHasData));
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////
  task automatic loadAc(input int ac, input int backoff, input int aifs);
    timers.backoffCnt[ac] <= backoffTrigPkg::backoffCnt_t'(backoff);
    timers.aifsCnt[ac]    <= backoffTrigPkg::aifsCnt_t'(aifs);
  endtask

  task automatic idleTimers();
    for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
      loadAc(i, 1000, 0);                       // far from the end
  endtask

  task automatic setQueue(input int ac, input backoffTrigPkg::dmaState_t st);
    txState[ac] <= st;
  endtask

  task automatic driveStrobes(input backoffTrigPkg::acVec_t setHd,
                              input backoffTrigPkg::acVec_t clrHd,
                              input backoffTrigPkg::acVec_t flagRst);
    @(posedge macCoreClk);
    hasDataCtrl <= {setHd, clrHd};
    flagReset   <= flagRst;
    @(posedge macCoreClk);
    hasDataCtrl <= '0;
    flagReset   <= '0;
  endtask

  task automatic stateEvent(input backoffTrigPkg::slotCnt_t trig,
                            input backoffTrigPkg::slotCnt_t slot);
    @(posedge macCoreClk);
    currentStateEvent <= 1'b1;
    edcaTriggerTimer  <= trig;
    slotTime          <= slot;
    @(posedge macCoreClk);
    currentStateEvent <= 1'b0;
    repeat (8) @(posedge macCoreClk);           // one quotient bit each
    @(negedge macCoreClk);
    assert (UUT.threshold === refThreshold)
    else stopRun($sformatf("Mismatch at %0t: threshold is %h, expected %h",
                           $time, UUT.threshold, refThreshold));
  endtask

  // called on a rising edge, inputs held until the pulse is over
  task automatic sendTick(input logic wantPulse);
    logic seen;
    seen = 1'b0;
    tickSlot1us_p <= 1'b1;
    @(posedge macCoreClk);
    tickSlot1us_p <= 1'b0;
    for (int c = 0; c < 4; c++)                 // pulse due on the 3rd
    begin
      @(negedge macCoreClk);
      seen = seen | (|protTrigger);
    end
    if (wantPulse && !seen)
      stopRun("no protocol trigger pulse within 4 cycles of the slot tick");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    backoffTrigPkg::slotCnt_t trig;
    backoffTrigPkg::slotCnt_t slot;
    int                       q;
    lfsrState           = 32'hb67e;
    macCoreClkHardRst_n <= 1'b0;
    currentStateEvent   <= 1'b0;
    backoffEnable       <= 1'b1;
    tickSlot1us_p       <= 1'b0;
    txInProgress        <= 1'b0;
    edcaTriggerTimer    <= '0;
    slotTime            <= 8'd1;
    slotCnt             <= '0;
    hasDataCtrl         <= '0;
    flagReset           <= '0;
    idleTimers();
    for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
      setQueue(i, backoffTrigPkg::dmaState_t'(4'd0));
    repeat (5) @(posedge macCoreClk);
    macCoreClkHardRst_n <= 1'b1;
    repeat (3) @(posedge macCoreClk);           // idle, nothing may pulse

    // has-data strobes, set wins on AC2, ends at 0111
    driveStrobes(4'b1011, 4'b0000, 4'b0000);
    driveStrobes(4'b0100, 4'b0101, 4'b0000);
    driveStrobes(4'b0001, 4'b1000, 4'b0000);
    stateEvent(8'd50, 8'd9);                    // q 5, rest 5

    // AC3 marked w/o data, AC2 equal with aifs 0, AC1 below
    @(posedge macCoreClk);
    idleTimers();
    loadAc(1, 4, 0);
    loadAc(2, 5, 0);
    loadAc(3, 3, 0);
    slotCnt <= 8'd5;
    sendTick(1'b1);
    @(posedge macCoreClk);
    sendTick(1'b0);                             // AC2 flagged, AC1 gets nothing
    @(posedge macCoreClk);
    setQueue(3, backoffTrigPkg::PASSIVE);       // AC3 takes selection, no data
    sendTick(1'b0);
    @(posedge macCoreClk);
    setQueue(3, backoffTrigPkg::ACTIVE);
    sendTick(1'b0);

    // flag reset, AC2 equal with nonzero aifs
    driveStrobes(4'b0000, 4'b0000, 4'b0100);
    setQueue(3, backoffTrigPkg::dmaState_t'(4'd0));
    loadAc(2, 5, 3);
    sendTick(1'b1);
    driveStrobes(4'b0000, 4'b0100, 4'b0000);    // clear drops the flag too
    driveStrobes(4'b0100, 4'b0000, 4'b0000);
    sendTick(1'b1);

    // tx busy suppresses, flag stays clear
    driveStrobes(4'b0000, 4'b0000, 4'b0100);
    txInProgress <= 1'b1;
    sendTick(1'b0);
    @(posedge macCoreClk);
    txInProgress <= 1'b0;
    sendTick(1'b1);
    driveStrobes(4'b0000, 4'b0000, 4'b0100);
    backoffEnable <= 1'b0;                      // marks held clear
    sendTick(1'b0);
    @(posedge macCoreClk);
    backoffEnable <= 1'b1;

    // random thresholds, counters around the quotient
    driveStrobes(4'b1111, 4'b0000, 4'b0000);
    for (int e = 0; e < 6; e++)
    begin
      trig = backoffTrigPkg::slotCnt_t'(randBits(8));
      slot = backoffTrigPkg::slotCnt_t'(randBits(8));
      if (slot == 8'd0)
        slot = 8'd1;
      stateEvent(trig, slot);
      q = int'(trig / slot);
      for (int t = 0; t < 6; t++)
      begin
        driveStrobes(4'b0000, 4'b0000, 4'b1111);
        for (int i = 0; i < backoffTrigPkg::NUM_AC; i++)
          loadAc(i, q + int'(randBits(2) % 3) - 1,
                 (randBits(1) == 32'd1) ? 0 : int'(randBits(4)));
        slotCnt      <= backoffTrigPkg::slotCnt_t'(randBits(8));
        txInProgress <= (randBits(3) == 32'd0);
        sendTick(1'b0);
      end
    end

    @(posedge macCoreClk);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+verification
design/backoffTrigPkg.sv
design/trigThresholdCalc.sv
design/acTrigDetect.sv
design/acPrioritySelect.sv
design/protTrigPulseGen.sv
design/backoffProtTrig.sv
verification/backoffProtTrigTb.sv

/* Makefile */
# Verilator build and run of the backoff protocol trigger testbench.
# The run target fails when the testbench stops with $fatal.

VERILATOR ?= verilator
TOP       := backoffProtTrigTb
FILELIST  := files.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
